// ==== data_cache.sv ====
// data_cache: direct-mapped write-through cache with backing memory and refill counter
`timescale 1ns/1ps

module data_cache (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ren,
    input  logic                wen,
    input  mem_pkg::word_addr_t addr,
    input  mem_pkg::word_t      wdata,
    output mem_pkg::word_t      rdata,
    output logic                stall
);

    import mem_pkg::*;

    // line arrays
    tag_t                  tag_mem   [LINE_COUNT];
    word_t                 line_data [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid;

    // backing word memory
    word_t backing_mem [MEM_WORDS];

    cache_state_t                   state;
    logic [$clog2(MISS_CYCLES)-1:0] refill_cnt;
    word_addr_t                     refill_addr;

    index_t   req_index;
    tag_t     req_tag;
    mem_idx_t req_mem_idx;
    index_t   fill_index;
    tag_t     fill_tag;
    mem_idx_t fill_mem_idx;

    logic hit;
    logic miss_start;
    logic refill_done;

    // request address fields
    assign req_index   = addr[INDEX_W-1:0];
    assign req_tag     = addr[WORD_ADDR_W-1:INDEX_W];
    assign req_mem_idx = addr[MEM_IDX_W-1:0];

    // latched miss address fields
    assign fill_index   = refill_addr[INDEX_W-1:0];
    assign fill_tag     = refill_addr[WORD_ADDR_W-1:INDEX_W];
    assign fill_mem_idx = refill_addr[MEM_IDX_W-1:0];

    assign hit   = valid[req_index] && (tag_mem[req_index] == req_tag);
    assign rdata = line_data[req_index];

    assign miss_start  = (state == CACHE_IDLE) && ren && !hit;
    assign refill_done = (state == CACHE_REFILL) && (refill_cnt == MISS_CYCLES - 1);

    // stall rises in the miss cycle and stays up through refill
    assign stall = (state == CACHE_REFILL) || (ren && !hit);

    // refill FSM and valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= CACHE_IDLE;
            refill_cnt <= '0;
            valid      <= '0;
        end else begin
            case (state)
                CACHE_IDLE: begin
                    if (miss_start) begin
                        state      <= CACHE_REFILL;
                        refill_cnt <= '0;
                    end
                end
                CACHE_REFILL: begin
                    if (refill_done) begin
                        state             <= CACHE_IDLE;
                        valid[fill_index] <= 1'b1;
                    end else begin
                        refill_cnt <= refill_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= CACHE_IDLE;
                end
            endcase
        end
    end

    // remember which word is being fetched
    always_ff @(posedge clk) begin
        if (miss_start) begin
            refill_addr <= addr;
        end
    end

    // line fill, or write-hit update
    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_mem[fill_index]   <= fill_tag;
            line_data[fill_index] <= backing_mem[fill_mem_idx];
        end else if (wen && hit) begin
            line_data[req_index] <= wdata;
        end
    end

    // write-through, no allocate on miss
    always_ff @(posedge clk) begin
        if (wen) begin
            backing_mem[req_mem_idx] <= wdata;
        end
    end

endmodule

// ==== mem_pkg.sv ====
// shared widths, typedefs, cache localparams and cache state enum
package mem_pkg;

    // datapath widths
    localparam int WORD_W      = 32;
    localparam int WORD_ADDR_W = 30;
    localparam int REG_IDX_W   = 5;
    localparam int REG_COUNT   = 32;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [REG_IDX_W-1:0]   reg_idx_t;

    // cache geometry
    localparam int LINE_COUNT = 16;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = WORD_ADDR_W - INDEX_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // backing store, low word address bits only so upper addresses alias
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    typedef logic [MEM_IDX_W-1:0] mem_idx_t;

    // refill latency after a read miss is seen
    localparam int MISS_CYCLES = 4;

    typedef enum logic {
        CACHE_IDLE,
        CACHE_REFILL
    } cache_state_t;

endpackage

// ==== mem_stage.sv ====
// mem_stage: EX/MEM to MEM/WB register with data cache request and stall hold
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    // EX/MEM fields
    input  mem_pkg::word_t     alu_result_in,
    input  mem_pkg::word_t     mem_wdata_in,
    input  logic               memrd_in,
    input  logic               memwr_in,
    input  mem_pkg::word_t     pc_plus_4_in,
    input  mem_pkg::reg_idx_t  rd_in,
    input  logic               mem2reg_in,
    input  logic               regwr_in,
    input  logic               jump_in,
    // MEM/WB fields
    output mem_pkg::word_t     alu_result_out,
    output mem_pkg::word_t     mem_data,
    output mem_pkg::word_t     pc_plus_4_out,
    output mem_pkg::reg_idx_t  rd_out,
    output logic               mem2reg_out,
    output logic               regwr_out,
    output logic               jump_out,
    // data cache side
    input  logic               dcache_stall,
    input  mem_pkg::word_t     dcache_rdata,
    output logic               dcache_ren,
    output logic               dcache_wen,
    output mem_pkg::word_addr_t dcache_addr,
    output mem_pkg::word_t     dcache_wdata,
    output logic               pipe_stall
);

    import mem_pkg::*;

    word_t load_data;

    // cache keeps words in the opposite byte order
    function automatic word_t byte_swap(input word_t data);
        byte_swap = {data[7:0], data[15:8], data[23:16], data[31:24]};
    endfunction

    // request goes straight through, no register
    assign dcache_ren   = memrd_in;
    assign dcache_wen   = memwr_in;
    assign dcache_addr  = alu_result_in[WORD_W-1:2];
    assign dcache_wdata = byte_swap(mem_wdata_in);

    // only a real memory access can stall the pipe
    assign pipe_stall = dcache_stall & (memrd_in | memwr_in);

    assign load_data = byte_swap(dcache_rdata);

    // control fields, bubble on stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem2reg_out <= 1'b0;
            regwr_out   <= 1'b0;
            jump_out    <= 1'b0;
        end else if (pipe_stall) begin
            regwr_out   <= 1'b0;
        end else begin
            mem2reg_out <= mem2reg_in;
            regwr_out   <= regwr_in;
            jump_out    <= jump_in;
        end
    end

    // payload fields held while stalled
    always_ff @(posedge clk) begin
        if (!pipe_stall) begin
            alu_result_out <= alu_result_in;
            mem_data       <= load_data;
            pc_plus_4_out  <= pc_plus_4_in;
            rd_out         <= rd_in;
        end
    end

endmodule

// ==== mem_wb_tb.sv ====
// mem_wb_tb: vector-driven testbench for the memory stage, data cache and write-back unit
`timescale 1ns/1ps

module mem_wb_tb;

    import mem_pkg::*;

    localparam int STALL_TIMEOUT = 50;
    localparam int RESET_TIMEOUT = 20;

    logic     clk;
    logic     rst_n;
    word_t    alu_result_in;
    word_t    mem_wdata_in;
    logic     memrd_in;
    logic     memwr_in;
    word_t    pc_plus_4_in;
    reg_idx_t rd_in;
    logic     mem2reg_in;
    logic     regwr_in;
    logic     jump_in;
    reg_idx_t rs_addr;
    logic     pipe_stall;
    word_t    rs_data;

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_wb_top mem_wb_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .alu_result_in (alu_result_in),
        .mem_wdata_in  (mem_wdata_in),
        .memrd_in      (memrd_in),
        .memwr_in      (memwr_in),
        .pc_plus_4_in  (pc_plus_4_in),
        .rd_in         (rd_in),
        .mem2reg_in    (mem2reg_in),
        .regwr_in      (regwr_in),
        .jump_in       (jump_in),
        .rs_addr       (rs_addr),
        .pipe_stall    (pipe_stall),
        .rs_data       (rs_data)
    );

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    // bubble: no access, no register write
    task automatic drive_idle();
        alu_result_in = '0;
        mem_wdata_in  = '0;
        memrd_in      = 1'b0;
        memwr_in      = 1'b0;
        pc_plus_4_in  = '0;
        rd_in         = '0;
        mem2reg_in    = 1'b0;
        regwr_in      = 1'b0;
        jump_in       = 1'b0;
    endtask

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        while (rst_n !== 1'b1) begin
            waited++;
            if (waited > RESET_TIMEOUT) begin
                stop_with_error("reset was never released");
            end
            @(posedge clk);
        end
    endtask

    // address set on a falling edge, value sampled at the next rising edge
    task automatic check_register(input reg_idx_t idx, input word_t expected);
        @(negedge clk);
        rs_addr = idx;
        @(posedge clk);
        assert (rs_data === expected) else begin
            stop_with_error($sformatf("[FAIL] rs_data x%0d expected %h actual %h",
                                      idx, expected, rs_data));
        end
    endtask

    task automatic run_op(input logic [63:0] kind, input reg_idx_t rd, input word_t addr_val,
                          input word_t wdata, input word_t pc4, input word_t expected,
                          input logic exp_miss);
        int   waited;
        logic saw_stall;
        @(negedge clk);
        drive_idle();
        alu_result_in = addr_val;
        pc_plus_4_in  = pc4;
        rd_in         = rd;
        if (kind == "store") begin
            memwr_in     = 1'b1;
            mem_wdata_in = wdata;
        end else if (kind == "load") begin
            memrd_in   = 1'b1;
            mem2reg_in = 1'b1;
            regwr_in   = 1'b1;
        end else if (kind == "alu") begin
            regwr_in = 1'b1;
        end else if (kind == "jump") begin
            jump_in  = 1'b1;
            regwr_in = 1'b1;
        end else begin
            stop_with_error("unknown operation kind in vector file");
        end
        // inputs held until an edge without stall accepts them
        waited    = 0;
        saw_stall = 1'b0;
        @(posedge clk);
        while (pipe_stall !== 1'b0) begin
            saw_stall = 1'b1;
            waited++;
            if (waited > STALL_TIMEOUT) begin
                stop_with_error("pipe_stall never fell within the timeout");
            end
            @(posedge clk);
        end
        assert (saw_stall === exp_miss) else begin
            stop_with_error($sformatf("[FAIL] pipe_stall expected %h actual %h",
                                      exp_miss, saw_stall));
        end
        @(negedge clk);
        drive_idle();
        @(posedge clk);
        check_register(rd, expected);
    endtask

    initial begin
        int          fd;
        int          code;
        int          fields;
        int          op_count;
        string       line;
        logic [63:0] kind_txt;
        reg_idx_t    v_rd;
        word_t       v_addr;
        word_t       v_wdata;
        word_t       v_pc4;
        word_t       v_expected;
        logic        v_miss;

        drive_idle();
        rs_addr  = '0;
        op_count = 0;
        wait_for_reset();

        // register file comes out of reset cleared
        for (int i = 0; i < REG_COUNT; i++) begin
            check_register(reg_idx_t'(i), '0);
        end

        fd = $fopen("mem_wb_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open mem_wb_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
                kind_txt = '0;
                fields = $sscanf(line, "%s %h %h %h %h %h %h", kind_txt, v_rd, v_addr,
                                 v_wdata, v_pc4, v_expected, v_miss);
                if (fields != 7) begin
                    stop_with_error("malformed line in mem_wb_vectors.txt");
                end
                run_op(kind_txt, v_rd, v_addr, v_wdata, v_pc4, v_expected, v_miss);
                op_count++;
            end
        end
        $fclose(fd);

        if (op_count == 0) begin
            stop_with_error("no operations found in mem_wb_vectors.txt");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== mem_wb_top.sv ====
// mem_wb_top: memory stage, data cache and write-back unit wired together
`timescale 1ns/1ps

module mem_wb_top (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::word_t    alu_result_in,
    input  mem_pkg::word_t    mem_wdata_in,
    input  logic              memrd_in,
    input  logic              memwr_in,
    input  mem_pkg::word_t    pc_plus_4_in,
    input  mem_pkg::reg_idx_t rd_in,
    input  logic              mem2reg_in,
    input  logic              regwr_in,
    input  logic              jump_in,
    input  mem_pkg::reg_idx_t rs_addr,
    output logic              pipe_stall,
    output mem_pkg::word_t    rs_data
);

    import mem_pkg::*;

    // cache request path
    logic       dcache_ren;
    logic       dcache_wen;
    word_addr_t dcache_addr;
    word_t      dcache_wdata;
    word_t      dcache_rdata;
    logic       dcache_stall;

    // MEM/WB fields
    word_t    wb_alu_result;
    word_t    wb_mem_data;
    word_t    wb_pc_plus_4;
    reg_idx_t wb_rd;
    logic     wb_mem2reg;
    logic     wb_regwr;
    logic     wb_jump;

    mem_stage mem_stage_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_result_in  (alu_result_in),
        .mem_wdata_in   (mem_wdata_in),
        .memrd_in       (memrd_in),
        .memwr_in       (memwr_in),
        .pc_plus_4_in   (pc_plus_4_in),
        .rd_in          (rd_in),
        .mem2reg_in     (mem2reg_in),
        .regwr_in       (regwr_in),
        .jump_in        (jump_in),
        .alu_result_out (wb_alu_result),
        .mem_data       (wb_mem_data),
        .pc_plus_4_out  (wb_pc_plus_4),
        .rd_out         (wb_rd),
        .mem2reg_out    (wb_mem2reg),
        .regwr_out      (wb_regwr),
        .jump_out       (wb_jump),
        .dcache_stall   (dcache_stall),
        .dcache_rdata   (dcache_rdata),
        .dcache_ren     (dcache_ren),
        .dcache_wen     (dcache_wen),
        .dcache_addr    (dcache_addr),
        .dcache_wdata   (dcache_wdata),
        .pipe_stall     (pipe_stall)
    );

    data_cache data_cache_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .ren   (dcache_ren),
        .wen   (dcache_wen),
        .addr  (dcache_addr),
        .wdata (dcache_wdata),
        .rdata (dcache_rdata),
        .stall (dcache_stall)
    );

    writeback_unit writeback_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_result (wb_alu_result),
        .mem_data   (wb_mem_data),
        .pc_plus_4  (wb_pc_plus_4),
        .rd         (wb_rd),
        .mem2reg    (wb_mem2reg),
        .regwr      (wb_regwr),
        .jump       (wb_jump),
        .rs_addr    (rs_addr),
        .rs_data    (rs_data)
    );

endmodule

// ==== mem_wb_vectors.txt ====
# kind rd addr_or_alu store_data pc_plus_4 expected_rd_value stall_expected
# all numbers hex, addresses are byte addresses, stall_expected is 1 where a load misses
alu   01 12345678 00000000 00000004 12345678 0
alu   02 cafef00d 00000000 00000008 cafef00d 0
store 00 00000040 deadbeef 0000000c 00000000 0
load  03 00000040 00000000 00000010 deadbeef 1
load  04 00000040 00000000 00000014 deadbeef 0
store 00 00000040 a5a55a5a 00000018 00000000 0
load  05 00000040 00000000 0000001c a5a55a5a 0
jump  06 00000000 00000000 00000020 00000020 0
alu   00 ffffffff 00000000 00000024 00000000 0
jump  00 00000000 00000000 00000028 00000000 0
store 00 00000080 11223344 0000002c 00000000 0
load  07 00000080 00000000 00000030 11223344 1
load  08 00000040 00000000 00000034 a5a55a5a 1
load  09 00000080 00000000 00000038 11223344 1
store 00 00000104 0badc0de 0000003c 00000000 0
load  0a 00000104 00000000 00000040 0badc0de 1
alu   01 00000abc 00000000 00000044 00000abc 0
load  0b 00000104 00000000 00000048 0badc0de 0

// ==== tb_clock_gen.sv ====
// tb_clock_gen: 100 ns testbench clock and synchronous reset held for three cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // low for three rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== vlog.f ====
mem_pkg.sv
mem_stage.sv
data_cache.sv
writeback_unit.sv
mem_wb_top.sv
tb_clock_gen.sv
mem_wb_tb.sv

// ==== writeback_unit.sv ====
// writeback_unit: write-back source select and register file with one read port
`timescale 1ns/1ps

module writeback_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::word_t    alu_result,
    input  mem_pkg::word_t    mem_data,
    input  mem_pkg::word_t    pc_plus_4,
    input  mem_pkg::reg_idx_t rd,
    input  logic              mem2reg,
    input  logic              regwr,
    input  logic              jump,
    input  mem_pkg::reg_idx_t rs_addr,
    output mem_pkg::word_t    rs_data
);

    import mem_pkg::*;

    word_t regs [REG_COUNT];
    word_t wb_data;

    // jump link has priority over load data
    always_comb begin
        if (jump) begin
            wb_data = pc_plus_4;
        end else if (mem2reg) begin
            wb_data = mem_data;
        end else begin
            wb_data = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regwr && (rd != '0)) begin
            regs[rd] <= wb_data;
        end
    end

    // x0 reads as zero
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];

endmodule
